// ==== verilog/tft_pkg.sv ====
package tft_pkg;

    // one byte on the serial link
    typedef logic [7:0] tft_byte_t;
    // pixel column or row, high byte goes out first
    typedef logic [15:0] tft_coord_t;
    // rgb565 pixel, high byte first
    typedef logic [15:0] tft_color_t;
    // init table entry, dc flag above the byte
    typedef logic [8:0] init_entry_t;

    // window and memory write commands
    localparam tft_byte_t cmd_caset = 8'h2a;
    localparam tft_byte_t cmd_raset = 8'h2b;
    localparam tft_byte_t cmd_ramwr = 8'h2c;

    localparam int init_len = 7;

    // dc low marks a command, dc high its parameter
    localparam init_entry_t init_table [init_len] = '{
        // software reset
        {1'b0, 8'h01},
        // sleep out
        {1'b0, 8'h11},
        // pixel format, 16 bit
        {1'b0, 8'h3a},
        {1'b1, 8'h05},
        // memory access control
        {1'b0, 8'h36},
        {1'b1, 8'h00},
        // display on
        {1'b0, 8'h29}
    };

    localparam tft_color_t wall_color = 16'hffff;
    localparam tft_color_t back_color = 16'h0000;
    localparam tft_color_t player_color = 16'hf800;

endpackage

// ==== verilog/maze_pkg.sv ====
package maze_pkg;

    // grid size in cells
    localparam int grid_w = 10;
    localparam int grid_h = 15;

    // wall on top of cell (c, r) at bit r*grid_w + c
    typedef logic [(grid_h + 1) * grid_w - 1:0] h_walls_t;
    // wall left of cell (c, r) at bit r*(grid_w+1) + c
    typedef logic [grid_h * (grid_w + 1) - 1:0] v_walls_t;

    typedef logic [3:0] cell_t;

    // value is {button_1, button_2}
    typedef enum logic [1:0] {
        dir_right = 2'd0,
        dir_down  = 2'd1,
        dir_left  = 2'd2,
        dir_up    = 2'd3
    } dir_t;

    // top level sequencer
    typedef enum logic [1:0] {
        phase_idle,
        phase_init,
        phase_scene,
        phase_player
    } phase_t;

endpackage

// ==== verilog/tft_spi.sv ====
`timescale 1ns/1ps

module tft_spi import tft_pkg::*; (
    input  logic      clk,
    input  logic      rst,
    input  tft_byte_t data,
    input  logic      dc,
    input  logic      transmit,
    output logic      tft_mosi,
    output logic      tft_dc,
    output logic      tft_clk,
    output logic      busy
);

    // byte being shifted, msb first
    tft_byte_t shift_reg;
    // half-bit counter, even low phase, odd high phase
    logic [3:0] phase_cnt;
    logic dc_reg;

    assign tft_dc = dc_reg;

    // payload
    always_ff @(posedge clk) begin
        if (transmit && !busy) begin
            shift_reg <= data;
            dc_reg <= dc;
        end else if (busy && phase_cnt[0]) begin
            shift_reg <= {shift_reg[6:0], 1'b0};
        end
    end

    always_ff @(posedge clk) begin
        if (!rst) begin
            busy <= 1'b0;
            tft_clk <= 1'b0;
            tft_mosi <= 1'b0;
            phase_cnt <= '0;
        end else if (transmit && !busy) begin
            busy <= 1'b1;
            tft_clk <= 1'b0;
            tft_mosi <= data[7];
            phase_cnt <= '0;
        end else if (busy) begin
            phase_cnt <= phase_cnt + 4'd1;
            if (!phase_cnt[0]) begin
                tft_clk <= 1'b1;
            end else begin
                tft_clk <= 1'b0;
                // next bit, zero once the byte is out
                tft_mosi <= shift_reg[6];
                if (phase_cnt == 4'd15)
                    busy <= 1'b0;
            end
        end
    end

endmodule

// ==== verilog/tft_init.sv ====
`timescale 1ns/1ps

module tft_init import tft_pkg::*; (
    input  logic      clk,
    input  logic      rst,
    input  logic      enable,
    input  logic      tft_busy,
    output tft_byte_t tft_data,
    output logic      tft_dc,
    output logic      tft_transmit,
    output logic      busy
);

    // entry sent next
    logic [2:0] idx;
    logic finished;
    // pulse last cycle, busy not yet up
    logic pulsed;

    assign busy = enable && !finished;
    assign tft_transmit = busy && !tft_busy && !pulsed;

    assign tft_data = init_table[idx][7:0];
    assign tft_dc = init_table[idx][8];

    always_ff @(posedge clk) begin
        if (!rst) begin
            pulsed <= 1'b0;
        end else begin
            pulsed <= tft_transmit;
        end
    end

    // table walk, restarts when enable drops
    always_ff @(posedge clk) begin
        if (!rst || !enable) begin
            idx <= '0;
            finished <= 1'b0;
        end else if (tft_transmit) begin
            if (idx == 3'(init_len - 1))
                finished <= 1'b1;
            else
                idx <= idx + 3'd1;
        end
    end

endmodule

// ==== verilog/tft_rect_writer.sv ====
`timescale 1ns/1ps

module tft_rect_writer import tft_pkg::*; (
    input  logic       clk,
    input  logic       rst,
    input  logic       start,
    input  tft_coord_t x0,
    input  tft_coord_t y0,
    input  tft_coord_t x1,
    input  tft_coord_t y1,
    input  tft_color_t color,
    input  logic       tft_busy,
    output tft_byte_t  tft_data,
    output logic       tft_dc,
    output logic       tft_transmit,
    output logic       done
);

    typedef enum logic [1:0] {
        st_idle,
        st_window,
        st_command,
        st_pixel
    } state_t;

    state_t state;
    tft_coord_t x0_r;
    tft_coord_t y0_r;
    tft_coord_t x1_r;
    tft_coord_t y1_r;
    tft_color_t color_r;
    tft_coord_t width;
    tft_coord_t height;
    // window byte index, bit 0 picks the pixel half
    logic [3:0] byte_cnt;
    // pixels left to send
    logic [31:0] pix_cnt;
    logic pulsed;

    assign width = x1 - x0 + 16'd1;
    assign height = y1 - y0 + 16'd1;

    assign tft_transmit = (state != st_idle) && !tft_busy && !pulsed;
    // low byte of the last pixel accepted
    assign done = tft_transmit && (state == st_pixel) && byte_cnt[0] && (pix_cnt == 32'd1);

    always_comb begin
        tft_dc = 1'b1;
        tft_data = '0;
        case (state)
            st_window: begin
                case (byte_cnt)
                    4'd0: tft_data = cmd_caset;
                    4'd1: tft_data = x0_r[15:8];
                    4'd2: tft_data = x0_r[7:0];
                    4'd3: tft_data = x1_r[15:8];
                    4'd4: tft_data = x1_r[7:0];
                    4'd5: tft_data = cmd_raset;
                    4'd6: tft_data = y0_r[15:8];
                    4'd7: tft_data = y0_r[7:0];
                    4'd8: tft_data = y1_r[15:8];
                    default: tft_data = y1_r[7:0];
                endcase
                // commands sit at 0 and 5
                tft_dc = !(byte_cnt == 4'd0 || byte_cnt == 4'd5);
            end
            st_command: begin
                tft_data = cmd_ramwr;
                tft_dc = 1'b0;
            end
            st_pixel: tft_data = byte_cnt[0] ? color_r[7:0] : color_r[15:8];
            default: ;
        endcase
    end

    // rectangle sampled on start
    always_ff @(posedge clk) begin
        if (start && state == st_idle) begin
            x0_r <= x0;
            y0_r <= y0;
            x1_r <= x1;
            y1_r <= y1;
            color_r <= color;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst) begin
            state <= st_idle;
            byte_cnt <= '0;
            pix_cnt <= '0;
            pulsed <= 1'b0;
        end else begin
            pulsed <= tft_transmit;
            case (state)
                st_idle: if (start) begin
                    state <= st_window;
                    byte_cnt <= '0;
                    pix_cnt <= {16'd0, width} * {16'd0, height};
                end
                st_window: if (tft_transmit) begin
                    byte_cnt <= byte_cnt + 4'd1;
                    if (byte_cnt == 4'd9)
                        state <= st_command;
                end
                st_command: if (tft_transmit) begin
                    state <= st_pixel;
                    byte_cnt <= '0;
                end
                default: if (tft_transmit) begin
                    byte_cnt <= {3'd0, !byte_cnt[0]};
                    if (byte_cnt[0]) begin
                        pix_cnt <= pix_cnt - 32'd1;
                        if (pix_cnt == 32'd1)
                            state <= st_idle;
                    end
                end
            endcase
        end
    end

endmodule

// ==== verilog/scene_exhibitor.sv ====
`timescale 1ns/1ps

module scene_exhibitor import tft_pkg::*, maze_pkg::*; #(
    parameter int cell_size = 32
) (
    input  logic      clk,
    input  logic      rst,
    input  logic      enable,
    input  h_walls_t  h_walls,
    input  v_walls_t  v_walls,
    input  logic      tft_busy,
    output tft_byte_t tft_data,
    output logic      tft_dc,
    output logic      tft_transmit,
    output logic      busy
);

    localparam tft_coord_t cs = tft_coord_t'(cell_size);

    typedef enum logic {sc_scan, sc_draw} state_t;

    state_t state;
    // bit index into the current bitmap
    logic [7:0] idx;
    cell_t col;
    cell_t row;
    // low for horizontal walls, high for vertical
    logic vert;
    logic finished;
    logic wall_set;
    logic last_wall;
    logic step;
    cell_t last_col;
    cell_t last_row;
    tft_coord_t col_px;
    tft_coord_t row_px;
    tft_coord_t x1;
    tft_coord_t y1;
    logic wr_start;
    logic wr_done;

    assign wall_set = vert ? v_walls[idx] : h_walls[idx];
    // vertical bitmap has one extra column, horizontal one extra row
    assign last_col = vert ? cell_t'(grid_w) : cell_t'(grid_w - 1);
    assign last_row = vert ? cell_t'(grid_h - 1) : cell_t'(grid_h);
    assign last_wall = vert && col == last_col && row == last_row;

    assign busy = enable && !finished;
    assign wr_start = busy && state == sc_scan && wall_set;
    // clear bits cost one cycle each
    assign step = busy && ((state == sc_scan && !wall_set) || (state == sc_draw && wr_done));

    assign col_px = tft_coord_t'(col) * cs;
    assign row_px = tft_coord_t'(row) * cs;
    // two pixel thick walls
    assign x1 = vert ? col_px + 16'd1 : col_px + cs - 16'd1;
    assign y1 = vert ? row_px + cs - 16'd1 : row_px + 16'd1;

    always_ff @(posedge clk) begin
        if (!rst || !enable) begin
            state <= sc_scan;
            idx <= '0;
            col <= '0;
            row <= '0;
            vert <= 1'b0;
            finished <= 1'b0;
        end else if (wr_start) begin
            state <= sc_draw;
        end else if (step) begin
            state <= sc_scan;
            if (last_wall) begin
                finished <= 1'b1;
            end else begin
                idx <= idx + 8'd1;
                col <= col + 4'd1;
                if (col == last_col) begin
                    col <= '0;
                    row <= row + 4'd1;
                    // horizontal done, vertical bitmap from bit 0
                    if (row == last_row) begin
                        row <= '0;
                        vert <= 1'b1;
                        idx <= '0;
                    end
                end
            end
        end
    end

    tft_rect_writer rect_writer (
        .clk          (clk),
        .rst          (rst),
        .start        (wr_start),
        .x0           (col_px),
        .y0           (row_px),
        .x1           (x1),
        .y1           (y1),
        .color        (wall_color),
        .tft_busy     (tft_busy),
        .tft_data     (tft_data),
        .tft_dc       (tft_dc),
        .tft_transmit (tft_transmit),
        .done         (wr_done)
    );

endmodule

// ==== verilog/player.sv ====
`timescale 1ns/1ps

module player import tft_pkg::*, maze_pkg::*; #(
    parameter int cell_size = 32
) (
    input  logic      clk,
    input  logic      rst,
    input  logic      enable,
    input  cell_t     old_x,
    input  cell_t     old_y,
    input  cell_t     new_x,
    input  cell_t     new_y,
    input  logic      tft_busy,
    output tft_byte_t tft_data,
    output logic      tft_dc,
    output logic      tft_transmit,
    output logic      busy
);

    localparam tft_coord_t cs = tft_coord_t'(cell_size);

    typedef enum logic {pl_erase, pl_draw} step_t;

    step_t step;
    // writer started and not yet done
    logic running;
    logic finished;
    cell_t sel_x;
    cell_t sel_y;
    tft_coord_t base_x;
    tft_coord_t base_y;
    tft_color_t color;
    logic wr_start;
    logic wr_done;

    assign busy = enable && !finished;
    assign wr_start = busy && !running;

    // erase at the old cell, draw at the new one
    assign sel_x = (step == pl_erase) ? old_x : new_x;
    assign sel_y = (step == pl_erase) ? old_y : new_y;
    assign color = (step == pl_erase) ? back_color : player_color;
    assign base_x = tft_coord_t'(sel_x) * cs;
    assign base_y = tft_coord_t'(sel_y) * cs;

    always_ff @(posedge clk) begin
        if (!rst || !enable) begin
            step <= pl_erase;
            running <= 1'b0;
            finished <= 1'b0;
        end else if (wr_start) begin
            running <= 1'b1;
        end else if (wr_done) begin
            running <= 1'b0;
            if (step == pl_draw)
                finished <= 1'b1;
            else
                step <= pl_draw;
        end
    end

    // square inset 2 pixels on every side
    tft_rect_writer rect_writer (
        .clk          (clk),
        .rst          (rst),
        .start        (wr_start),
        .x0           (base_x + 16'd2),
        .y0           (base_y + 16'd2),
        .x1           (base_x + cs - 16'd3),
        .y1           (base_y + cs - 16'd3),
        .color        (color),
        .tft_busy     (tft_busy),
        .tft_data     (tft_data),
        .tft_dc       (tft_dc),
        .tft_transmit (tft_transmit),
        .done         (wr_done)
    );

endmodule

// ==== verilog/maze.sv ====
`timescale 1ns/1ps

module maze import tft_pkg::*, maze_pkg::*; #(
    parameter int cell_size = 32
) (
    input  logic     clk,
    input  logic     rst,
    input  logic     button_1,
    input  logic     button_2,
    input  h_walls_t h_walls,
    input  v_walls_t v_walls,
    output logic     tft_rst,
    output logic     tft_clk,
    output logic     tft_mosi,
    output logic     tft_dc
);

    localparam logic [7:0] gw = 8'(grid_w);
    localparam logic [7:0] gw1 = 8'(grid_w + 1);

    phase_t phase;
    tft_byte_t init_data;
    tft_byte_t scene_data;
    tft_byte_t player_data;
    tft_byte_t spi_data;
    logic init_dc, scene_dc, player_dc, spi_dc;
    logic init_transmit, scene_transmit, player_transmit, spi_transmit;
    logic init_busy, scene_busy, player_busy, spi_busy;
    logic init_enable, scene_enable, player_enable;
    dir_t button_reg;
    // cell drawn last frame and cell drawn this frame
    cell_t old_x, old_y, cur_x, cur_y;
    cell_t next_x, next_y;
    // wall bits around the current cell
    logic [7:0] h_top, h_bot, v_left, v_right;

    assign tft_rst = rst;
    assign init_enable = (phase == phase_init);
    assign scene_enable = (phase == phase_scene);

    // byte link of the active producer, none in idle
    always_comb begin
        spi_data = '0;
        spi_dc = 1'b0;
        spi_transmit = 1'b0;
        case (phase)
            phase_init: begin
                spi_data = init_data;
                spi_dc = init_dc;
                spi_transmit = init_transmit;
            end
            phase_scene: begin
                spi_data = scene_data;
                spi_dc = scene_dc;
                spi_transmit = scene_transmit;
            end
            phase_player: begin
                spi_data = player_data;
                spi_dc = player_dc;
                spi_transmit = player_transmit;
            end
            default: ;
        endcase
    end

    assign h_top = {4'd0, cur_y} * gw + {4'd0, cur_x};
    assign h_bot = h_top + gw;
    assign v_left = {4'd0, cur_y} * gw1 + {4'd0, cur_x};
    assign v_right = v_left + 8'd1;

    // one step, refused at the grid edge or a set wall
    always_comb begin
        next_x = cur_x;
        next_y = cur_y;
        case (button_reg)
            dir_right: if (cur_x != cell_t'(grid_w - 1) && !v_walls[v_right])
                next_x = cur_x + 4'd1;
            dir_down: if (cur_y != cell_t'(grid_h - 1) && !h_walls[h_bot])
                next_y = cur_y + 4'd1;
            dir_left: if (cur_x != '0 && !v_walls[v_left])
                next_x = cur_x - 4'd1;
            default: if (cur_y != '0 && !h_walls[h_top])
                next_y = cur_y - 4'd1;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst) begin
            phase <= phase_idle;
            player_enable <= 1'b0;
            button_reg <= dir_right;
            old_x <= '0;
            old_y <= '0;
            cur_x <= '0;
            cur_y <= '0;
        end else begin
            case (phase)
                phase_idle: phase <= phase_init;
                phase_init: if (!init_busy) phase <= phase_scene;
                phase_scene: if (!scene_busy) begin
                    // first frame at (0,0), no move
                    phase <= phase_player;
                    player_enable <= 1'b1;
                end
                default: begin
                    if (player_enable) begin
                        if (!player_busy) begin
                            player_enable <= 1'b0;
                            button_reg <= dir_t'({button_1, button_2});
                        end
                    end else begin
                        // enable low for this one cycle
                        old_x <= cur_x;
                        old_y <= cur_y;
                        cur_x <= next_x;
                        cur_y <= next_y;
                        player_enable <= 1'b1;
                    end
                end
            endcase
        end
    end

    tft_spi spi_transmitter (
        .clk      (clk),
        .rst      (rst),
        .data     (spi_data),
        .dc       (spi_dc),
        .transmit (spi_transmit),
        .tft_mosi (tft_mosi),
        .tft_dc   (tft_dc),
        .tft_clk  (tft_clk),
        .busy     (spi_busy)
    );

    tft_init tft_initializer (
        .clk          (clk),
        .rst          (rst),
        .enable       (init_enable),
        .tft_busy     (spi_busy),
        .tft_data     (init_data),
        .tft_dc       (init_dc),
        .tft_transmit (init_transmit),
        .busy         (init_busy)
    );

    scene_exhibitor #(.cell_size(cell_size)) scene (
        .clk          (clk),
        .rst          (rst),
        .enable       (scene_enable),
        .h_walls      (h_walls),
        .v_walls      (v_walls),
        .tft_busy     (spi_busy),
        .tft_data     (scene_data),
        .tft_dc       (scene_dc),
        .tft_transmit (scene_transmit),
        .busy         (scene_busy)
    );

    player #(.cell_size(cell_size)) player_draw (
        .clk          (clk),
        .rst          (rst),
        .enable       (player_enable),
        .old_x        (old_x),
        .old_y        (old_y),
        .new_x        (cur_x),
        .new_y        (cur_y),
        .tft_busy     (spi_busy),
        .tft_data     (player_data),
        .tft_dc       (player_dc),
        .tft_transmit (player_transmit),
        .busy         (player_busy)
    );

endmodule

// ==== tests/maze_assert.sv ====
`timescale 1ns/1ps

module maze_assert (
    input logic clk,
    input logic rst,
    input logic transmit,
    input logic busy,
    input logic tft_clk,
    input logic tft_dc
);

    // failed assertions so far
    int fail_count = 0;

    // idle straight out of reset
    reset_idle: assert property (@(posedge clk) !rst |=> !busy && !tft_clk)
        else begin
            fail_count++;
            $error("transmitter busy or serial clock high after reset");
        end

    // no serial clock between bytes
    clk_quiet: assert property (@(posedge clk) disable iff (!rst) !busy |-> !tft_clk)
        else begin
            fail_count++;
            $error("serial clock high while transmitter idle");
        end

    // producers hold off while a byte shifts out
    no_overrun: assert property (@(posedge clk) disable iff (!rst) busy |-> !transmit)
        else begin
            fail_count++;
            $error("transmit pulse while transmitter busy");
        end

    dc_hold: assert property (@(posedge clk) disable iff (!rst)
        busy |=> !busy || $stable(tft_dc))
        else begin
            fail_count++;
            $error("dc changed during a byte");
        end

endmodule

bind tft_spi maze_assert spi_checks (
    .clk      (clk),
    .rst      (rst),
    .transmit (transmit),
    .busy     (busy),
    .tft_clk  (tft_clk),
    .tft_dc   (tft_dc)
);

// ==== tests/maze_tb.sv ====
`timescale 1ns/1ps

module maze_tb import tft_pkg::*, maze_pkg::*;;

    localparam int cs = 8;
    // first frame plus twelve moves
    localparam int n_frames = 13;
    // player square edge in pixels
    localparam int sq = cs - 4;

    logic clk;
    logic rst;
    logic button_1;
    logic button_2;
    h_walls_t h_walls;
    v_walls_t v_walls;
    logic tft_rst;
    logic tft_clk;
    logic tft_mosi;
    logic tft_dc;

    // model copies of the wall bitmaps
    h_walls_t hw;
    v_walls_t vw;
    logic [31:0] lfsr_state;
    // expected {dc, byte} stream
    logic [8:0] exp_q [$];
    int byte_idx;
    int scene_end;
    int frame_idx;
    int frame_bytes;
    int frame_expect;
    int errs [0:5];
    int refused;
    logic caset_odd;
    // model player cell
    int mx;
    int my;
    logic [1:0] pending_dir;
    logic all_done;
    int cycles;
    int limit;
    // serial byte decoder
    logic [7:0] rx_shift;
    int rx_bits;
    logic sclk_prev;

    always #10 clk = ~clk;

    maze #(.cell_size(cs)) DUT (
        .clk      (clk),
        .rst      (rst),
        .button_1 (button_1),
        .button_2 (button_2),
        .h_walls  (h_walls),
        .v_walls  (v_walls),
        .tft_rst  (tft_rst),
        .tft_clk  (tft_clk),
        .tft_mosi (tft_mosi),
        .tft_dc   (tft_dc)
    );

    // fibonacci lfsr with taps 32 22 2 1
    function automatic logic take_bit();
        logic fb;
        fb = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
        lfsr_state = {lfsr_state[30:0], fb};
        return fb;
    endfunction

    // window commands and a solid run of pixels
    task automatic push_rect(input int x0, input int y0, input int x1, input int y1,
                             input tft_color_t color);
        int n;
        n = (x1 - x0 + 1) * (y1 - y0 + 1);
        exp_q.push_back({1'b0, 8'h2a});
        exp_q.push_back({1'b1, 8'(x0 >> 8)});
        exp_q.push_back({1'b1, 8'(x0)});
        exp_q.push_back({1'b1, 8'(x1 >> 8)});
        exp_q.push_back({1'b1, 8'(x1)});
        exp_q.push_back({1'b0, 8'h2b});
        exp_q.push_back({1'b1, 8'(y0 >> 8)});
        exp_q.push_back({1'b1, 8'(y0)});
        exp_q.push_back({1'b1, 8'(y1 >> 8)});
        exp_q.push_back({1'b1, 8'(y1)});
        exp_q.push_back({1'b0, 8'h2c});
        for (int i = 0; i < n; i++) begin
            exp_q.push_back({1'b1, color[15:8]});
            exp_q.push_back({1'b1, color[7:0]});
        end
    endtask

    // square inset 2 pixels inside the cell
    task automatic push_square(input int c, input int r, input tft_color_t color);
        push_rect(c * cs + 2, r * cs + 2, c * cs + cs - 3, r * cs + cs - 3, color);
    endtask

    // one step unless the edge or a wall is in the way
    task automatic move_cell(input int x, input int y, input logic [1:0] d,
                             output int nx, output int ny);
        nx = x;
        ny = y;
        case (d)
            2'd0: if (x < grid_w - 1 && !vw[y * (grid_w + 1) + x + 1])
                nx = x + 1;
            2'd1: if (y < grid_h - 1 && !hw[(y + 1) * grid_w + x])
                ny = y + 1;
            2'd2: if (x > 0 && !vw[y * (grid_w + 1) + x])
                nx = x - 1;
            default: if (y > 0 && !hw[y * grid_w + x])
                ny = y - 1;
        endcase
    endtask

    task automatic print_result(input int n, input string name);
        if (errs[n] == 0)
            $display("test %0d %s: ok", n, name);
        else
            $display("test %0d %s: %0d errors", n, name, errs[n]);
    endtask

    // builds the expected frame and drives the buttons for the next one
    task automatic start_frame();
        int nx;
        int ny;
        logic b1;
        logic b2;
        nx = 0;
        ny = 0;
        if (frame_idx > 0) begin
            move_cell(mx, my, pending_dir, nx, ny);
            if (nx == mx && ny == my)
                refused++;
        end
        push_square(mx, my, back_color);
        push_square(nx, ny, player_color);
        mx = nx;
        my = ny;
        frame_expect = 2 * 11 + 2 * 2 * sq * sq;
        b1 = take_bit();
        b2 = take_bit();
        button_1 <= b1;
        button_2 <= b2;
        pending_dir = {b1, b2};
    endtask

    task automatic close_frame();
        assert (frame_bytes == frame_expect) else begin
            $display("FAIL %0t: frame %0d before byte %0d has %0d bytes, expected %0d",
                     $time, frame_idx, byte_idx, frame_bytes, frame_expect);
            errs[5]++;
        end
        if (frame_idx == 0)
            print_result(3, "first player frame");
        if (frame_idx == n_frames - 1) begin
            print_result(4, "random moves");
            print_result(5, "frame byte counts");
        end
    endtask

    task automatic check_byte(input logic dc, input logic [7:0] b);
        logic [8:0] got;
        logic [8:0] want;
        int t;
        if (all_done)
            return;
        got = {dc, b};
        // every other caset in the player phase is an erase window
        if (byte_idx >= scene_end && !dc && b == 8'h2a) begin
            if (!caset_odd) begin
                if (frame_idx >= 0)
                    close_frame();
                frame_idx++;
                frame_bytes = 0;
                if (frame_idx == n_frames) begin
                    all_done = 1'b1;
                    return;
                end
                start_frame();
            end
            caset_odd = !caset_odd;
        end
        if (byte_idx < init_len)
            t = 1;
        else if (byte_idx < scene_end)
            t = 2;
        else if (frame_idx <= 0)
            t = 3;
        else
            t = 4;
        if (byte_idx >= scene_end)
            frame_bytes++;
        assert (exp_q.size() > 0) else begin
            $display("byte %0d arrived at %0t with nothing left to expect", byte_idx, $time);
            errs[t]++;
        end
        if (exp_q.size() > 0) begin
            want = exp_q.pop_front();
            assert (got == want) else begin
                $display("FAIL %0t: byte %0d got dc %b data %h, expected dc %b data %h",
                         $time, byte_idx, got[8], got[7:0], want[8], want[7:0]);
                errs[t]++;
            end
        end
        byte_idx++;
        if (byte_idx == init_len)
            print_result(1, "init sequence");
        if (byte_idx == scene_end)
            print_result(2, "scene walls");
    endtask

    // mosi and dc taken where tft_clk was seen rising
    always @(posedge clk) begin
        if (!rst) begin
            rx_bits = 0;
            sclk_prev = 1'b0;
        end else begin
            if (tft_clk && !sclk_prev) begin
                rx_shift = {rx_shift[6:0], tft_mosi};
                rx_bits++;
                if (rx_bits == 8) begin
                    rx_bits = 0;
                    check_byte(tft_dc, rx_shift);
                end
            end
            sclk_prev = tft_clk;
        end
    end

    // panel reset mirrors the system reset
    always @(posedge clk) begin
        assert (tft_rst === rst) else begin
            $display("FAIL %0t: tft_rst is %b while rst is %b", $time, tft_rst, rst);
            errs[0]++;
        end
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles > limit) begin
            $display("timeout after %0d cycles with %0d bytes decoded", cycles, byte_idx);
            $display("Test failed");
            $finish;
        end
    end

    initial begin
        int fails;
        int asserts;
        clk = 1'b0;
        rst = 1'b0;
        button_1 = 1'b0;
        button_2 = 1'b0;
        h_walls = '0;
        v_walls = '0;
        lfsr_state = 32'h7235_355b;
        byte_idx = 0;
        frame_idx = -1;
        frame_bytes = 0;
        frame_expect = 0;
        refused = 0;
        caset_odd = 1'b0;
        mx = 0;
        my = 0;
        pending_dir = 2'd0;
        all_done = 1'b0;
        cycles = 0;
        rx_bits = 0;
        rx_shift = '0;
        sclk_prev = 1'b0;
        for (int i = 0; i <= 5; i++)
            errs[i] = 0;
        // interior walls at one in four
        for (int i = 0; i < (grid_h + 1) * grid_w; i++)
            hw[i] = take_bit() & take_bit();
        for (int i = 0; i < grid_h * (grid_w + 1); i++)
            vw[i] = take_bit() & take_bit();
        // closed border
        for (int c = 0; c < grid_w; c++) begin
            hw[c] = 1'b1;
            hw[grid_h * grid_w + c] = 1'b1;
        end
        for (int r = 0; r < grid_h; r++) begin
            vw[r * (grid_w + 1)] = 1'b1;
            vw[r * (grid_w + 1) + grid_w] = 1'b1;
        end
        // reset, sleep out, pixel format, memory access control, display on
        exp_q.push_back({1'b0, 8'h01});
        exp_q.push_back({1'b0, 8'h11});
        exp_q.push_back({1'b0, 8'h3a});
        exp_q.push_back({1'b1, 8'h05});
        exp_q.push_back({1'b0, 8'h36});
        exp_q.push_back({1'b1, 8'h00});
        exp_q.push_back({1'b0, 8'h29});
        // horizontal walls then vertical ones in bit order
        for (int r = 0; r <= grid_h; r++)
            for (int c = 0; c < grid_w; c++)
                if (hw[r * grid_w + c])
                    push_rect(c * cs, r * cs, c * cs + cs - 1, r * cs + 1, wall_color);
        for (int r = 0; r < grid_h; r++)
            for (int c = 0; c <= grid_w; c++)
                if (vw[r * (grid_w + 1) + c])
                    push_rect(c * cs, r * cs, c * cs + 1, r * cs + cs - 1, wall_color);
        scene_end = exp_q.size();
        // 17 cycles per byte plus 20% margin
        // one extra frame closes the last one
        limit = (scene_end + (n_frames + 1) * (22 + 4 * sq * sq)) * 17 * 12 / 10;
        @(posedge clk);
        h_walls <= hw;
        v_walls <= vw;
        repeat (4) @(posedge clk);
        rst <= 1'b1;
        while (!all_done)
            @(posedge clk);
        print_result(0, "panel reset");
        fails = errs[0] + errs[1] + errs[2] + errs[3] + errs[4] + errs[5];
        asserts = DUT.spi_transmitter.spi_checks.fail_count;
        $display("%0d bytes, %0d errors, %0d assertion failures, %0d of %0d moves refused",
                 byte_idx, fails, asserts, refused, n_frames - 1);
        if (fails + asserts == 0) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

// ==== list.f ====
verilog/tft_pkg.sv
verilog/maze_pkg.sv
verilog/tft_spi.sv
verilog/tft_init.sv
verilog/tft_rect_writer.sv
verilog/scene_exhibitor.sv
verilog/player.sv
verilog/maze.sv
tests/maze_assert.sv
tests/maze_tb.sv

// ==== Bender.yml ====
package:
  name: maze

sources:
  - verilog/tft_pkg.sv
  - verilog/maze_pkg.sv
  - verilog/tft_spi.sv
  - verilog/tft_init.sv
  - verilog/tft_rect_writer.sv
  - verilog/scene_exhibitor.sv
  - verilog/player.sv
  - verilog/maze.sv
  - target: test
    files:
      - tests/maze_assert.sv
      - tests/maze_tb.sv
